// ==== source/sonic_status_pkg.sv ====
//////////////////////////////
// sonic status package
// field widths, training-state codes and control/status
// register bit positions shared by the status glue
//////////////////////////////
package sonic_status_pkg;

   // field widths
   localparam int LTSSM_WIDTH = 5;
   localparam int LANE_WIDTH  = 4;
   localparam int ICM_WIDTH   = LTSSM_WIDTH + LANE_WIDTH;
   localparam int REG_WIDTH   = 32;

   typedef logic [LTSSM_WIDTH-1:0] ltssm_t;      // training state
   typedef logic [LANE_WIDTH-1:0]  lane_mask_t;  // active lanes
   typedef logic [ICM_WIDTH-1:0]   icm_status_t; // {lane mask, ltssm}
   typedef logic [REG_WIDTH-1:0]   reg_word_t;

   // lane mask sits above the training state
   localparam int ICM_LANE_LSB = LTSSM_WIDTH;

   // training-state codes
   localparam ltssm_t LTSSM_COMPLIANCE = 5'b00011;
   localparam ltssm_t LTSSM_L0         = 5'b01111;

   // alive counter, top bit toggles roughly every 0.3 s at 125 MHz
   localparam int ALIVE_WIDTH = 26;

   // control register bits, bit 0 unused
   localparam int CTRL_RATE_SEL1 = 1;
   localparam int CTRL_RATE_SEL2 = 2;
   localparam int CTRL_TX_DIS1   = 3;
   localparam int CTRL_TX_DIS2   = 4;
   localparam int CTRL_PWRDN1    = 5;
   localparam int CTRL_PWRDN2    = 6;

   // status word 1, bit 0 reserved, bit 1 is the compliance-mode bit
   localparam int STS1_ICM_LSB = 2;

   // status word 0 field positions above the control readback
   localparam int STS0_TX_FAULT2 = CTRL_PWRDN2 + 1;
   localparam int STS0_TX_FAULT1 = CTRL_PWRDN2 + 2;
   localparam int STS0_MOD1      = CTRL_PWRDN2 + 3;
   localparam int STS0_MOD2      = CTRL_PWRDN2 + 4;

endpackage

// ==== source/link_led_monitor.sv ====
//////////////////////////////
// link led monitor
// core-domain reset synchronizer, alive blinker
// and decode of the link training state to leds
//////////////////////////////
`timescale 1ns/1ps

module link_led_monitor #(
   parameter int alive_width = sonic_status_pkg::ALIVE_WIDTH
) (
   input  logic                            clk_out_buf,
   input  logic                            pcie_rstn,
   input  logic                            local_rstn_ext,
   input  sonic_status_pkg::icm_status_t   test_out_icm,
   input  logic                            gen2_speed,
   output logic                            any_rstn_rr,
   output logic                            alive_led,
   output logic                            comp_led,
   output logic                            l0_led,
   output sonic_status_pkg::lane_mask_t    lane_active_led,
   output logic                            gen2_led
);

   logic                         any_rstn;     // either reset source
   logic                         any_rstn_r;
   logic [alive_width-1:0]       alive_cnt;
   sonic_status_pkg::ltssm_t     ltssm;
   sonic_status_pkg::lane_mask_t lane_mask;

   assign any_rstn = pcie_rstn & local_rstn_ext;

   // split the status word into its fields
   assign ltssm     = test_out_icm[sonic_status_pkg::LTSSM_WIDTH-1:0];
   assign lane_mask = test_out_icm[sonic_status_pkg::ICM_WIDTH-1:
                                   sonic_status_pkg::ICM_LANE_LSB];

   // async assert, release after two edges
   always_ff @(posedge clk_out_buf or negedge any_rstn)
   begin
      if (!any_rstn)
      begin
         any_rstn_r  <= 1'b0;
         any_rstn_rr <= 1'b0;
      end
      else
      begin
         any_rstn_r  <= 1'b1;
         any_rstn_rr <= any_rstn_r;
      end
   end

   // free-running blinker
   always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
   begin
      if (!any_rstn_rr)
      begin
         alive_cnt <= '0;
         alive_led <= 1'b0;
      end
      else
      begin
         alive_cnt <= alive_cnt + 1'b1;
         alive_led <= alive_cnt[alive_width-1];  // top bit, one cycle late
      end
   end

   // training state decode
   always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
   begin
      if (!any_rstn_rr)
      begin
         comp_led        <= 1'b0;
         l0_led          <= 1'b0;
         lane_active_led <= '0;
         gen2_led        <= 1'b0;
      end
      else
      begin
         comp_led        <= (ltssm == sonic_status_pkg::LTSSM_COMPLIANCE);
         l0_led          <= (ltssm == sonic_status_pkg::LTSSM_L0);
         lane_active_led <= lane_mask;
         gen2_led        <= gen2_speed;
      end
   end

   // the link cannot be in compliance and L0 at once
   a_comp_l0_exclusive : assert property (
      @(posedge clk_out_buf) disable iff (!any_rstn_rr)
      !(comp_led && l0_led)
   )
   else $error("comp_led and l0_led both high");

endmodule

// ==== source/gray_status_crosser.sv ====
//////////////////////////////
// gray status crosser
// moves the 9-bit link status word from the
// core clock into the management clock in gray code
//////////////////////////////
`timescale 1ns/1ps

module gray_status_crosser (
   input  logic                            clk_out_buf,
   input  logic                            any_rstn_rr,
   input  logic                            clk_mm,
   input  logic                            local_rstn_ext,
   input  sonic_status_pkg::icm_status_t   test_out_icm,
   output sonic_status_pkg::icm_status_t   icm_mm
);

   sonic_status_pkg::icm_status_t src_gray;   // launch register, core domain
   sonic_status_pkg::icm_status_t dst_meta;   // first capture stage
   sonic_status_pkg::icm_status_t dst_sync;

   function automatic sonic_status_pkg::icm_status_t bin2gray(
      input sonic_status_pkg::icm_status_t bin
   );
      return bin ^ (bin >> 1);
   endfunction

   function automatic sonic_status_pkg::icm_status_t gray2bin(
      input sonic_status_pkg::icm_status_t gray
   );
      sonic_status_pkg::icm_status_t bin;
      bin[sonic_status_pkg::ICM_WIDTH-1] = gray[sonic_status_pkg::ICM_WIDTH-1];
      for (int i = sonic_status_pkg::ICM_WIDTH-2; i >= 0; i--)
      begin
         bin[i] = bin[i+1] ^ gray[i];  // running xor from the msb down
      end
      return bin;
   endfunction

   // source side
   always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
   begin
      if (!any_rstn_rr)
         src_gray <= '0;
      else
         src_gray <= bin2gray(test_out_icm);
   end

   // destination side, two flops then decode
   always_ff @(posedge clk_mm or negedge local_rstn_ext)
   begin
      if (!local_rstn_ext)
      begin
         dst_meta <= '0;
         dst_sync <= '0;
         icm_mm   <= '0;
      end
      else
      begin
         dst_meta <= src_gray;
         dst_sync <= dst_meta;
         icm_mm   <= gray2bin(dst_sync);
      end
   end

   // an X here would spread into the mm domain unseen
   a_src_known : assert property (
      @(posedge clk_out_buf) disable iff (!any_rstn_rr)
      !$isunknown(src_gray)
   )
   else $error("gray source register holds an unknown value");

endmodule

// ==== source/sfp_ctrl_reg.sv ====
//////////////////////////////
// sfp control register
// management-domain register driving the sfp
// rate-select, tx-disable and lane power-down pins
//////////////////////////////
`timescale 1ns/1ps

module sfp_ctrl_reg (
   input  logic                          clk_mm,
   input  logic                          local_rstn_ext,
   input  logic                          ctrl_wr,
   input  sonic_status_pkg::reg_word_t   ctrl_data,
   output sonic_status_pkg::reg_word_t   ctrl_word,
   output logic                          sfp1_rate_sel,    // high above 4.25 GBd
   output logic                          sfp2_rate_sel,
   output logic                          sfp1_tx_disable,
   output logic                          sfp2_tx_disable,
   output logic                          lane1_prwdn,
   output logic                          lane2_prwdn,
   output logic                          phy_reset_n
);

   always_ff @(posedge clk_mm or negedge local_rstn_ext)
   begin
      if (!local_rstn_ext)
         ctrl_word <= '0;
      else if (ctrl_wr)
         ctrl_word <= ctrl_data;  // last word written
   end

   // pin breakout
   assign sfp1_rate_sel   = ctrl_word[sonic_status_pkg::CTRL_RATE_SEL1];
   assign sfp2_rate_sel   = ctrl_word[sonic_status_pkg::CTRL_RATE_SEL2];
   assign sfp1_tx_disable = ctrl_word[sonic_status_pkg::CTRL_TX_DIS1];
   assign sfp2_tx_disable = ctrl_word[sonic_status_pkg::CTRL_TX_DIS2];
   assign lane1_prwdn     = ctrl_word[sonic_status_pkg::CTRL_PWRDN1];
   assign lane2_prwdn     = ctrl_word[sonic_status_pkg::CTRL_PWRDN2];

   assign phy_reset_n = local_rstn_ext;  // phy held in reset with the board

   a_wr_data_known : assert property (
      @(posedge clk_mm) disable iff (!local_rstn_ext)
      ctrl_wr |-> !$isunknown(ctrl_data)
   )
   else $error("ctrl_data unknown during a register write");

endmodule

// ==== source/status_word_builder.sv ====
//////////////////////////////
// status word builder
// synchronizes the sfp pins and registers the two
// readback words for the management processor
//////////////////////////////
`timescale 1ns/1ps

module status_word_builder (
   input  logic                            clk_mm,
   input  logic                            local_rstn_ext,
   input  sonic_status_pkg::reg_word_t     ctrl_word,
   input  sonic_status_pkg::icm_status_t   icm_mm,
   input  logic                            phy_reset_n,
   input  logic                            sfp1_mod,
   input  logic                            sfp2_mod,
   input  logic                            sfp1_tx_fault,
   input  logic                            sfp2_tx_fault,
   output sonic_status_pkg::reg_word_t     status_word_0,
   output sonic_status_pkg::reg_word_t     status_word_1
);

   logic [3:0]                  pin_meta;  // {mod2, mod1, fault1, fault2}
   logic [3:0]                  pin_sync;
   sonic_status_pkg::reg_word_t sts0_next;
   sonic_status_pkg::reg_word_t sts1_next;

   // async pins, two flops
   always_ff @(posedge clk_mm or negedge local_rstn_ext)
   begin
      if (!local_rstn_ext)
      begin
         pin_meta <= '0;
         pin_sync <= '0;
      end
      else
      begin
         pin_meta <= {sfp2_mod, sfp1_mod, sfp1_tx_fault, sfp2_tx_fault};
         pin_sync <= pin_meta;
      end
   end

   // word 0 packing, upper bits stay zero
   always_comb
   begin
      sts0_next    = '0;
      sts0_next[0] = phy_reset_n;
      sts0_next[sonic_status_pkg::CTRL_PWRDN2:sonic_status_pkg::CTRL_RATE_SEL1] =
         ctrl_word[sonic_status_pkg::CTRL_PWRDN2:sonic_status_pkg::CTRL_RATE_SEL1];
      sts0_next[sonic_status_pkg::STS0_TX_FAULT2] = pin_sync[0];
      sts0_next[sonic_status_pkg::STS0_TX_FAULT1] = pin_sync[1];
      sts0_next[sonic_status_pkg::STS0_MOD1]      = pin_sync[2];
      sts0_next[sonic_status_pkg::STS0_MOD2]      = pin_sync[3];
   end

   // compliance-mode bit is tied low
   assign sts1_next = sonic_status_pkg::reg_word_t'(icm_mm) << sonic_status_pkg::STS1_ICM_LSB;

   always_ff @(posedge clk_mm or negedge local_rstn_ext)
   begin
      if (!local_rstn_ext)
      begin
         status_word_0 <= '0;
         status_word_1 <= '0;
      end
      else
      begin
         status_word_0 <= sts0_next;
         status_word_1 <= sts1_next;
      end
   end

endmodule

// ==== source/sonic_status_top.sv ====
//////////////////////////////
// sonic status top
// status and control glue around the pcie core:
// link leds, sfp/phy control pins and the
// management readback words
//////////////////////////////
`timescale 1ns/1ps

module sonic_status_top #(
   parameter int alive_width = sonic_status_pkg::ALIVE_WIDTH
) (
   input  logic                            clk_out_buf,
   input  logic                            clk_mm,
   input  logic                            pcie_rstn,
   input  logic                            local_rstn_ext,
   input  sonic_status_pkg::icm_status_t   test_out_icm,
   input  logic                            gen2_speed,
   input  logic                            ctrl_wr,
   input  sonic_status_pkg::reg_word_t     ctrl_data,
   input  logic                            sfp1_mod,
   input  logic                            sfp2_mod,
   input  logic                            sfp1_tx_fault,
   input  logic                            sfp2_tx_fault,
   output logic                            alive_led,
   output logic                            comp_led,
   output logic                            l0_led,
   output sonic_status_pkg::lane_mask_t    lane_active_led,
   output logic                            gen2_led,
   output logic                            phy_reset_n,
   output logic                            sfp1_rate_sel,
   output logic                            sfp2_rate_sel,
   output logic                            sfp1_tx_disable,
   output logic                            sfp2_tx_disable,
   output logic                            lane1_prwdn,
   output logic                            lane2_prwdn,
   output sonic_status_pkg::reg_word_t     status_word_0,
   output sonic_status_pkg::reg_word_t     status_word_1
);

   logic                          any_rstn_rr;  // synchronized core reset
   sonic_status_pkg::icm_status_t icm_mm;       // link status in clk_mm
   sonic_status_pkg::reg_word_t   ctrl_word;

   // core clock domain
   link_led_monitor #(
      .alive_width (alive_width)
   ) u_led_monitor (
      .clk_out_buf     (clk_out_buf),
      .pcie_rstn       (pcie_rstn),
      .local_rstn_ext  (local_rstn_ext),
      .test_out_icm    (test_out_icm),
      .gen2_speed      (gen2_speed),
      .any_rstn_rr     (any_rstn_rr),
      .alive_led       (alive_led),
      .comp_led        (comp_led),
      .l0_led          (l0_led),
      .lane_active_led (lane_active_led),
      .gen2_led        (gen2_led)
   );

   gray_status_crosser u_icm_crosser (
      .clk_out_buf    (clk_out_buf),
      .any_rstn_rr    (any_rstn_rr),
      .clk_mm         (clk_mm),
      .local_rstn_ext (local_rstn_ext),
      .test_out_icm   (test_out_icm),
      .icm_mm         (icm_mm)
   );

   // management clock domain
   sfp_ctrl_reg u_ctrl_reg (
      .clk_mm          (clk_mm),
      .local_rstn_ext  (local_rstn_ext),
      .ctrl_wr         (ctrl_wr),
      .ctrl_data       (ctrl_data),
      .ctrl_word       (ctrl_word),
      .sfp1_rate_sel   (sfp1_rate_sel),
      .sfp2_rate_sel   (sfp2_rate_sel),
      .sfp1_tx_disable (sfp1_tx_disable),
      .sfp2_tx_disable (sfp2_tx_disable),
      .lane1_prwdn     (lane1_prwdn),
      .lane2_prwdn     (lane2_prwdn),
      .phy_reset_n     (phy_reset_n)
   );

   status_word_builder u_status (
      .clk_mm         (clk_mm),
      .local_rstn_ext (local_rstn_ext),
      .ctrl_word      (ctrl_word),
      .icm_mm         (icm_mm),
      .phy_reset_n    (phy_reset_n),
      .sfp1_mod       (sfp1_mod),
      .sfp2_mod       (sfp2_mod),
      .sfp1_tx_fault  (sfp1_tx_fault),
      .sfp2_tx_fault  (sfp2_tx_fault),
      .status_word_0  (status_word_0),
      .status_word_1  (status_word_1)
   );

endmodule

// ==== testbench/tb_clock_gen.sv ====
//////////////////////////////
// testbench clock and reset
// core and management clocks plus the board reset
//////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int reset_cycles = 16
) (
   output logic clk_out_buf,
   output logic clk_mm,
   output logic board_rstn
);

   initial
   begin
      clk_out_buf = 1'b0;
      forever #2 clk_out_buf = ~clk_out_buf;  // 4 ns core clock
   end

   initial
   begin
      clk_mm = 1'b0;
      forever #10 clk_mm = ~clk_mm;  // 20 ns
   end

   // released on a core clock edge
   initial
   begin
      board_rstn <= 1'b0;
      repeat (reset_cycles) @(posedge clk_out_buf);
      board_rstn <= 1'b1;
   end

endmodule

// ==== testbench/sonic_status_tb.sv ====
//////////////////////////////
// sonic status testbench
// lfsr stimulus, a cycle model of the leds and the
// control register, readback word checks
//////////////////////////////
`timescale 1ns/1ps

module sonic_status_tb;

   localparam int LED_CYCLES  = 1000;  // core cycles of random icm
   localparam int CTRL_CYCLES = 60;    // mm cycles of random writes
   localparam int PIN_ROUNDS  = 8;
   localparam int ICM_ROUNDS  = 10;
   // tests take about 2200 core cycles
   localparam int CYCLE_LIMIT = 4000;

   logic                          clk_out_buf;
   logic                          clk_mm;
   logic                          board_rstn;
   logic                          pcie_rstn;
   logic                          local_rstn_ext;
   sonic_status_pkg::icm_status_t test_out_icm;
   logic                          gen2_speed;
   logic                          ctrl_wr;
   sonic_status_pkg::reg_word_t   ctrl_data;
   logic                          sfp1_mod;
   logic                          sfp2_mod;
   logic                          sfp1_tx_fault;
   logic                          sfp2_tx_fault;
   logic                          alive_led;
   logic                          comp_led;
   logic                          l0_led;
   sonic_status_pkg::lane_mask_t  lane_active_led;
   logic                          gen2_led;
   logic                          phy_reset_n;
   logic                          sfp1_rate_sel;
   logic                          sfp2_rate_sel;
   logic                          sfp1_tx_disable;
   logic                          sfp2_tx_disable;
   logic                          lane1_prwdn;
   logic                          lane2_prwdn;
   sonic_status_pkg::reg_word_t   status_word_0;
   sonic_status_pkg::reg_word_t   status_word_1;

   logic [5:0]                    ctrl_pins;  // bits 1 to 6 of the register
   logic                          m_rst_r;    // model reset synchronizer
   logic                          m_rst_rr;
   logic [5:0]                    m_alive_cnt;
   logic                          m_alive_led;
   logic                          m_comp;
   logic                          m_l0;
   sonic_status_pkg::lane_mask_t  m_lanes;
   logic                          m_gen2;
   sonic_status_pkg::reg_word_t   m_ctrl;     // last word written
   logic                          check_en;
   logic [15:0]                   lfsr_state;
   int                            core_errors = 0;
   int                            seq_errors = 0;
   int                            cycle_count = 0;

   tb_clock_gen #(.reset_cycles(16)) clocks (
      .clk_out_buf (clk_out_buf),
      .clk_mm      (clk_mm),
      .board_rstn  (board_rstn)
   );

   assign pcie_rstn      = board_rstn;
   assign local_rstn_ext = board_rstn;

   sonic_status_top #(.alive_width(6)) uut (.*);

   assign ctrl_pins = {lane2_prwdn, lane1_prwdn, sfp2_tx_disable,
                       sfp1_tx_disable, sfp2_rate_sel, sfp1_rate_sel};

   // taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      logic feedback;
      feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
      return {state[14:0], feedback};
   endfunction

   task automatic draw_bits(input int count, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < count; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         value = {value[30:0], lfsr_state[0]};  // one step per bit
      end
   endtask

   function automatic int compare_value(input string test_name, input logic [31:0] expected,
                                        input logic [31:0] actual);
      int bad;
      bad = 0;
      assert (actual === expected)
      else
      begin
         bad = 1;
         $display("FAILED %s: expected 0x%h, actual 0x%h", test_name, expected, actual);
      end
      return bad;
   endfunction

   // phy, control bits, fault2, fault1, mod1, mod2 from bit 0 up
   function automatic logic [31:0] status0_expected(input logic phy, input logic [31:0] ctrl,
                                                    input logic fault2, input logic fault1,
                                                    input logic mod1, input logic mod2);
      logic [31:0] word;
      word       = '0;
      word[0]    = phy;
      word[6:1]  = ctrl[6:1];
      word[7]    = fault2;
      word[8]    = fault1;
      word[9]    = mod1;
      word[10]   = mod2;
      return word;
   endfunction

   function automatic logic [31:0] status1_expected(input logic [8:0] icm);
      logic [31:0] word;
      word       = '0;
      word[10:2] = icm;  // compliance bit stays low
      return word;
   endfunction

   task automatic check_reset_state(input string stage);
      seq_errors += compare_value({stage, " leds"}, 32'd0,
         32'({alive_led, comp_led, l0_led, lane_active_led, gen2_led}));
      seq_errors += compare_value({stage, " ctrl pins"}, 32'd0, 32'(ctrl_pins));
      seq_errors += compare_value({stage, " phy_reset_n"}, 32'(local_rstn_ext),
                                  32'(phy_reset_n));
      seq_errors += compare_value({stage, " status_word_0"}, 32'd0, status_word_0);
      seq_errors += compare_value({stage, " status_word_1"}, 32'd0, status_word_1);
   endtask

   // core domain model
   always @(posedge clk_out_buf)
   begin
      if (!(pcie_rstn && local_rstn_ext))
      begin
         m_rst_r  <= 1'b0;
         m_rst_rr <= 1'b0;
      end
      else
      begin
         m_rst_r  <= 1'b1;
         m_rst_rr <= m_rst_r;
      end
      if (!m_rst_rr)
      begin
         m_alive_cnt <= '0;
         m_alive_led <= 1'b0;
         m_comp      <= 1'b0;
         m_l0        <= 1'b0;
         m_lanes     <= '0;
         m_gen2      <= 1'b0;
      end
      else
      begin
         m_alive_cnt <= m_alive_cnt + 6'd1;
         m_alive_led <= m_alive_cnt[5];
         m_comp      <= (test_out_icm[4:0] == 5'b00011);  // compliance
         m_l0        <= (test_out_icm[4:0] == 5'b01111);  // L0
         m_lanes     <= test_out_icm[8:5];
         m_gen2      <= gen2_speed;
      end
   end

   always @(posedge clk_mm)
   begin
      if (!local_rstn_ext)
         m_ctrl <= '0;
      else if (ctrl_wr)
         m_ctrl <= ctrl_data;
   end

   // leds and pins are stable on every falling core edge
   always @(negedge clk_out_buf)
   begin
      if (check_en)
      begin
         core_errors += compare_value("alive_led", 32'(m_alive_led), 32'(alive_led));
         core_errors += compare_value("comp_led", 32'(m_comp), 32'(comp_led));
         core_errors += compare_value("l0_led", 32'(m_l0), 32'(l0_led));
         core_errors += compare_value("lane_active_led", 32'(m_lanes), 32'(lane_active_led));
         core_errors += compare_value("gen2_led", 32'(m_gen2), 32'(gen2_led));
         core_errors += compare_value("ctrl pins", 32'(m_ctrl[6:1]), 32'(ctrl_pins));
         core_errors += compare_value("phy_reset_n", 32'(local_rstn_ext), 32'(phy_reset_n));
      end
   end

   always @(posedge clk_out_buf)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("timeout: the run did not finish within %0d core cycles", CYCLE_LIMIT);
         $display("errors: core %0d, sequence %0d, total %0d",
                  core_errors, seq_errors, core_errors + seq_errors);
         $display("Simulation FAILED");
         $finish;
      end
   end

   initial
   begin
      logic [31:0] rnd;
      lfsr_state = 16'd51;
      check_en      <= 1'b0;
      test_out_icm  <= '0;
      gen2_speed    <= 1'b0;
      ctrl_wr       <= 1'b0;
      ctrl_data     <= '0;
      sfp1_mod      <= 1'b0;
      sfp2_mod      <= 1'b0;
      sfp1_tx_fault <= 1'b0;
      sfp2_tx_fault <= 1'b0;

      repeat (4) @(posedge clk_out_buf);
      check_en <= 1'b1;
      @(negedge clk_out_buf);
      while (!local_rstn_ext)
      begin
         check_reset_state("reset");
         @(negedge clk_out_buf);
      end
      check_reset_state("reset_release");

      // led decode and alive blink checked by the model every cycle
      repeat (LED_CYCLES)
      begin
         @(posedge clk_out_buf);
         draw_bits(10, rnd);
         test_out_icm <= rnd[8:0];
         gen2_speed   <= rnd[9];
      end

      repeat (CTRL_CYCLES)
      begin
         @(posedge clk_mm);
         draw_bits(1, rnd);
         ctrl_wr <= rnd[0];
         draw_bits(32, rnd);
         ctrl_data <= rnd;
      end
      @(posedge clk_mm);
      ctrl_wr <= 1'b0;

      // pins held 5 mm cycles with one register write per round
      repeat (PIN_ROUNDS)
      begin
         @(posedge clk_mm);
         draw_bits(4, rnd);
         {sfp2_mod, sfp1_mod, sfp1_tx_fault, sfp2_tx_fault} <= rnd[3:0];
         draw_bits(32, rnd);
         ctrl_data <= rnd;
         ctrl_wr   <= 1'b1;
         @(posedge clk_mm);
         ctrl_wr <= 1'b0;
         repeat (4) @(posedge clk_mm);
         @(negedge clk_mm);
         seq_errors += compare_value("status_word_0",
            status0_expected(local_rstn_ext, m_ctrl, sfp2_tx_fault, sfp1_tx_fault,
                             sfp1_mod, sfp2_mod), status_word_0);
      end

      repeat (ICM_ROUNDS)
      begin
         @(posedge clk_mm);
         draw_bits(9, rnd);
         test_out_icm <= rnd[8:0];
         repeat (12) @(posedge clk_mm);
         @(negedge clk_mm);
         seq_errors += compare_value("status_word_1", status1_expected(test_out_icm),
                                     status_word_1);
      end

      repeat (2) @(posedge clk_mm);
      $display("errors: core %0d, sequence %0d, total %0d",
               core_errors, seq_errors, core_errors + seq_errors);
      if (core_errors + seq_errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== Makefile ====
# Verilator build and run for the sonic status glue

VERILATOR ?= verilator
TOP       ?= sonic_status_tb
FILELIST  ?= sonic_status_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sonic_status_top.f ====
source/sonic_status_pkg.sv
source/link_led_monitor.sv
source/gray_status_crosser.sv
source/sfp_ctrl_reg.sv
source/status_word_builder.sv
source/sonic_status_top.sv
testbench/tb_clock_gen.sv
testbench/sonic_status_tb.sv
